// ==== logic/timer_config.svh ====
`ifndef TIMER_CONFIG_SVH
`define TIMER_CONFIG_SVH

// Counter and register width
`define TIMER_WIDTH 16
`define NUM_EVENTS 2

// Stable cycles per filter code, minus one
`define FILTER_LEN0 3'd0
`define FILTER_LEN1 3'd3
`define FILTER_LEN2 3'd5
`define FILTER_LEN3 3'd7

`define ADDR_WIDTH 4
`define BUS_DATA_WIDTH 16

// Register word addresses
`define ADDR_CTRL 4'h0
`define ADDR_MODE 4'h1
`define ADDR_EVCFG 4'h2
`define ADDR_IEN 4'h3
`define ADDR_ISR 4'h4
`define ADDR_STATUS 4'h5
`define ADDR_VALUE 4'h6
`define ADDR_PERIOD 4'h7
`define ADDR_PERIOD_SH 4'h8
`define ADDR_COMPARE 4'h9
`define ADDR_COMPARE_SH 4'ha
`define ADDR_POLARITY 4'hb

`endif

// ==== logic/timerPkg.sv ====
`default_nettype none
`include "timer_config.svh"

package timerPkg;

  typedef enum logic [`ADDR_WIDTH-1:0] {
    CTRL       = `ADDR_CTRL,
    MODE       = `ADDR_MODE,
    EVCFG      = `ADDR_EVCFG,
    IEN        = `ADDR_IEN,
    ISR        = `ADDR_ISR,
    STATUS     = `ADDR_STATUS,
    VALUE      = `ADDR_VALUE,
    PERIOD     = `ADDR_PERIOD,
    PERIOD_SH  = `ADDR_PERIOD_SH,
    COMPARE    = `ADDR_COMPARE,
    COMPARE_SH = `ADDR_COMPARE_SH,
    POLARITY   = `ADDR_POLARITY
  } regAddrE;

  typedef enum logic [1:0] {none, rising, falling, both} edgeSelE;
  typedef enum logic [1:0] {off, event0, event1} srcSelE; // Pin that starts or stops
  typedef enum logic {idle, running} runStateE;

  typedef struct packed {
    logic                       valid;
    logic                       write;
    logic [`ADDR_WIDTH-1:0]     addr;
    logic [`BUS_DATA_WIDTH-1:0] wdata;
  } busReqT;

  typedef struct packed {
    logic                       rValid;
    logic [`BUS_DATA_WIDTH-1:0] rdata;
  } busRspT;

  typedef struct packed {
    logic [1:0] filter;             // Index into FILTER_LEN0..3
    edgeSelE    edgeSel;
  } evCfgT;

  typedef struct packed {
    logic   countDown;
    logic   singleShot;
    srcSelE startSrc;
    srcSelE stopSrc;
    logic   stopClears;
  } modeT;

  // Single-cycle pulses decoded from a CTRL write
  typedef struct packed {
    logic runSet;
    logic runClear;
    logic counterClear;
  } ctrlCmdT;

  typedef struct packed {
    logic periodMatch;
    logic compareUp;
    logic zeroDown;
    logic event0;
    logic event1;
  } irqT;

  typedef struct packed {
    modeT                    mode;
    logic [`TIMER_WIDTH-1:0] period;
    logic [`TIMER_WIDTH-1:0] compare;
  } coreCfgT;

endpackage

`default_nettype wire

// ==== logic/eventConditioner.sv ====
`default_nettype none
`include "timer_config.svh"

module eventConditioner (
  input  logic            Clk,
  input  logic            reset,
  input  logic            pin,
  input  timerPkg::evCfgT cfg,
  output logic            edgePulse
);

  logic [2:0] filtCnt;
  logic [2:0] filtLen;
  logic filt;
  logic filtQ;
  logic rise;
  logic fall;

  always_comb begin
    case (cfg.filter)
      2'd0:    filtLen = `FILTER_LEN0;
      2'd1:    filtLen = `FILTER_LEN1;
      2'd2:    filtLen = `FILTER_LEN2;
      default: filtLen = `FILTER_LEN3;
    endcase
  end

  // Pin must stay away from the filtered level for filtLen+1 cycles
  always_ff @(posedge Clk) begin
    if (reset) begin
      filtCnt <= '0;
      filt    <= 1'b0;
    end else if (pin != filt) begin
      if (filtCnt == filtLen) begin
        filt    <= pin;
        filtCnt <= '0;
      end else begin
        filtCnt <= filtCnt + 3'd1;
      end
    end else begin
      filtCnt <= '0;                    // Glitch ended, start over
    end
  end

  assign rise = filt & ~filtQ;
  assign fall = ~filt & filtQ;

  always_ff @(posedge Clk) begin
    if (reset) begin
      filtQ     <= 1'b0;
      edgePulse <= 1'b0;
    end else begin
      filtQ <= filt;
      case (cfg.edgeSel)
        timerPkg::rising:  edgePulse <= rise;
        timerPkg::falling: edgePulse <= fall;
        timerPkg::both:    edgePulse <= rise | fall;
        default:           edgePulse <= 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/timerCore.sv ====
`default_nettype none
`include "timer_config.svh"

module timerCore (
  input  logic                    Clk,
  input  logic                    reset,
  input  timerPkg::coreCfgT       cfg,
  input  timerPkg::ctrlCmdT       cmd,
  input  logic [`NUM_EVENTS-1:0]  evEdge,
  output logic [`TIMER_WIDTH-1:0] value,
  output timerPkg::runStateE      runState,
  output logic                    wrap,
  output timerPkg::irqT           irqEv,
  output logic                    pwm
);

  logic isRunning;
  logic countDown;
  logic cmpMatch;
  logic prdMatch;
  logic zeroMatch;
  logic startEv;
  logic stopEv;
  logic clearCnt;

  function automatic logic selEdge(timerPkg::srcSelE sel, logic [`NUM_EVENTS-1:0] ev);
    case (sel)
      timerPkg::event0: selEdge = ev[0];
      timerPkg::event1: selEdge = ev[1];
      default:          selEdge = 1'b0;
    endcase
  endfunction

  assign isRunning = runState == timerPkg::running;
  assign countDown = cfg.mode.countDown;

  assign cmpMatch  = value == cfg.compare;
  assign prdMatch  = value == cfg.period;
  assign zeroMatch = value == '0;

  // End of one edge-aligned cycle
  assign wrap = isRunning & (countDown ? zeroMatch : prdMatch);

  assign startEv  = selEdge(cfg.mode.startSrc, evEdge);
  assign stopEv   = selEdge(cfg.mode.stopSrc, evEdge);
  assign clearCnt = cmd.counterClear | (stopEv & cfg.mode.stopClears);

  // Pin events are added by the register block
  assign irqEv = '{periodMatch: isRunning & ~countDown & prdMatch,
                   compareUp:   isRunning & ~countDown & cmpMatch,
                   zeroDown:    isRunning & countDown & zeroMatch,
                   event0:      1'b0,
                   event1:      1'b0};

  always_ff @(posedge Clk) begin
    if (reset) begin
      runState <= timerPkg::idle;
    end else if (cmd.runSet || startEv) begin
      runState <= timerPkg::running;
    end else if (cmd.runClear || stopEv || (wrap && cfg.mode.singleShot)) begin
      runState <= timerPkg::idle;
    end
  end

  always_ff @(posedge Clk) begin
    if (reset) begin
      value <= '0;
    end else if (clearCnt) begin
      value <= countDown ? cfg.period : '0;
    end else if (isRunning) begin
      if (countDown)
        value <= zeroMatch ? cfg.period : value - 1'b1;
      else
        value <= prdMatch ? '0 : value + 1'b1;
    end
  end

  always_ff @(posedge Clk) begin
    if (reset) begin
      pwm <= 1'b0;
    end else if (isRunning) begin
      if (countDown) begin
        if (cmpMatch)       pwm <= 1'b0;
        else if (zeroMatch) pwm <= 1'b1;
      end else begin
        if (cmpMatch)       pwm <= 1'b1;
        else if (prdMatch)  pwm <= 1'b0;
      end
    end else begin
      pwm <= value > cfg.compare;       // Static level when stopped
    end
  end

endmodule

`default_nettype wire

// ==== logic/timerRegs.sv ====
`default_nettype none
`include "timer_config.svh"

module timerRegs (
  input  logic                                  Clk,
  input  logic                                  reset,
  input  timerPkg::busReqT                      req,
  output timerPkg::busRspT                      rsp,
  input  logic [`TIMER_WIDTH-1:0]               value,
  input  timerPkg::runStateE                    runState,
  input  logic                                  wrap,
  input  timerPkg::irqT                         irqEv,
  input  logic [`NUM_EVENTS-1:0]                evEdge,
  output timerPkg::coreCfgT                     cfg,
  output timerPkg::ctrlCmdT                     cmd,
  output timerPkg::evCfgT [`NUM_EVENTS-1:0]     evCfg,
  output logic                                  polarity,
  output logic                                  irq
);

  timerPkg::modeT mode;
  timerPkg::irqT ien;
  timerPkg::irqT isr;
  timerPkg::irqT isrNext;
  timerPkg::irqT evAll;
  logic [`TIMER_WIDTH-1:0] period;
  logic [`TIMER_WIDTH-1:0] periodSh;
  logic [`TIMER_WIDTH-1:0] compare;
  logic [`TIMER_WIDTH-1:0] compareSh;
  logic [`TIMER_WIDTH-1:0] wdataT;
  logic [`BUS_DATA_WIDTH-1:0] rdataNext;
  logic [`BUS_DATA_WIDTH-1:0] rdataQ;
  logic rValidQ;
  logic wrEn;
  logic rdEn;
  logic isIdle;
  logic shadowLoad;

  assign wrEn = req.valid & req.write;  // Ready is always high
  assign rdEn = req.valid & ~req.write;
  assign wdataT = req.wdata[`TIMER_WIDTH-1:0];
  assign isIdle = runState == timerPkg::idle;
  assign shadowLoad = isIdle | wrap;

  assign cmd = (wrEn && req.addr == timerPkg::CTRL) ?
               timerPkg::ctrlCmdT'(req.wdata[$bits(timerPkg::ctrlCmdT)-1:0]) : '0;

  always_ff @(posedge Clk) begin
    if (reset) begin
      mode      <= '0;
      ien       <= '0;
      evCfg     <= '0;
      polarity  <= 1'b0;
      period    <= '0;
      periodSh  <= '0;
      compare   <= '0;
      compareSh <= '0;
    end else begin
      if (wrEn && req.addr == timerPkg::MODE)
        mode <= timerPkg::modeT'(req.wdata[$bits(timerPkg::modeT)-1:0]);
      if (wrEn && req.addr == timerPkg::IEN)
        ien <= timerPkg::irqT'(req.wdata[$bits(timerPkg::irqT)-1:0]);
      if (wrEn && req.addr == timerPkg::EVCFG)
        evCfg <= req.wdata[$bits(evCfg)-1:0];
      if (wrEn && req.addr == timerPkg::POLARITY)
        polarity <= req.wdata[0];

      // Active register written directly, shadow kept in step
      if (wrEn && (req.addr == timerPkg::PERIOD || req.addr == timerPkg::PERIOD_SH))
        periodSh <= wdataT;
      if (wrEn && (req.addr == timerPkg::PERIOD || (req.addr == timerPkg::PERIOD_SH && isIdle)))
        period <= wdataT;
      else if (shadowLoad)
        period <= periodSh;             // Transfer on wrap or while idle

      if (wrEn && (req.addr == timerPkg::COMPARE || req.addr == timerPkg::COMPARE_SH))
        compareSh <= wdataT;
      if (wrEn && (req.addr == timerPkg::COMPARE || (req.addr == timerPkg::COMPARE_SH && isIdle)))
        compare <= wdataT;
      else if (shadowLoad)
        compare <= compareSh;
    end
  end

  assign cfg = '{mode: mode, period: period, compare: compare};

  always_comb begin
    evAll = irqEv;
    evAll.event0 = irqEv.event0 | evEdge[0];  // Pin edges join the core sources
    evAll.event1 = irqEv.event1 | evEdge[1];
    isrNext = isr;
    if (wrEn && req.addr == timerPkg::ISR)
      isrNext = isr & ~timerPkg::irqT'(req.wdata[$bits(timerPkg::irqT)-1:0]);
    isrNext = isrNext | (evAll & ien);        // Set beats clear
  end

  always_ff @(posedge Clk) begin
    if (reset) begin
      isr <= '0;
      irq <= 1'b0;
    end else begin
      isr <= isrNext;
      irq <= |isrNext;                  // Tracks ISR in the same cycle
    end
  end

  always_comb begin
    rdataNext = '0;
    case (req.addr)
      timerPkg::MODE:       rdataNext[$bits(timerPkg::modeT)-1:0] = mode;
      timerPkg::EVCFG:      rdataNext[$bits(evCfg)-1:0] = evCfg;
      timerPkg::IEN:        rdataNext[$bits(timerPkg::irqT)-1:0] = ien;
      timerPkg::ISR:        rdataNext[$bits(timerPkg::irqT)-1:0] = isr;
      timerPkg::STATUS:     rdataNext[0] = ~isIdle;
      timerPkg::VALUE:      rdataNext[`TIMER_WIDTH-1:0] = value;
      timerPkg::PERIOD:     rdataNext[`TIMER_WIDTH-1:0] = period;
      timerPkg::PERIOD_SH:  rdataNext[`TIMER_WIDTH-1:0] = periodSh;
      timerPkg::COMPARE:    rdataNext[`TIMER_WIDTH-1:0] = compare;
      timerPkg::COMPARE_SH: rdataNext[`TIMER_WIDTH-1:0] = compareSh;
      timerPkg::POLARITY:   rdataNext[0] = polarity;
      default:              rdataNext = '0;  // CTRL and unused words
    endcase
  end

  always_ff @(posedge Clk) begin
    if (reset) rValidQ <= 1'b0;
    else       rValidQ <= rdEn;
  end

  always_ff @(posedge Clk) begin
    if (rdEn) rdataQ <= rdataNext;
  end

  assign rsp = '{rValid: rValidQ, rdata: rdataQ};

endmodule

`default_nettype wire

// ==== logic/pwmTimer.sv ====
`default_nettype none
`include "timer_config.svh"

module pwmTimer (
  input  logic                   Clk,
  input  logic                   reset,
  input  timerPkg::busReqT       req,
  output logic                   ready,
  output timerPkg::busRspT       rsp,
  input  logic [`NUM_EVENTS-1:0] evPin,
  output logic                   pwmOut,
  output logic                   irq
);

  timerPkg::coreCfgT cfg;
  timerPkg::ctrlCmdT cmd;
  timerPkg::evCfgT [`NUM_EVENTS-1:0] evCfg;
  timerPkg::runStateE runState;
  timerPkg::irqT irqEv;
  logic [`NUM_EVENTS-1:0] evEdge;
  logic [`TIMER_WIDTH-1:0] value;
  logic wrap;
  logic pwm;
  logic polarity;

  timerRegs regs_i (
    .Clk(Clk), .reset(reset), .req(req), .rsp(rsp), .value(value),
    .runState(runState), .wrap(wrap), .irqEv(irqEv), .evEdge(evEdge),
    .cfg(cfg), .cmd(cmd), .evCfg(evCfg), .polarity(polarity), .irq(irq)
  );

  for (genvar n = 0; n < `NUM_EVENTS; n++) begin : genEvent
    eventConditioner cond_i (
      .Clk(Clk), .reset(reset), .pin(evPin[n]), .cfg(evCfg[n]), .edgePulse(evEdge[n])
    );
  end

  timerCore core_i (
    .Clk(Clk), .reset(reset), .cfg(cfg), .cmd(cmd), .evEdge(evEdge),
    .value(value), .runState(runState), .wrap(wrap), .irqEv(irqEv), .pwm(pwm)
  );

  assign ready  = 1'b1;                 // No wait states yet
  assign pwmOut = pwm ^ polarity;       // Polarity 1 gives active low

endmodule

`default_nettype wire

// ==== tests/timer_assert.sv ====
`default_nettype none

module timerAssert (
  input logic             Clk,
  input logic             reset,
  input timerPkg::busReqT req,
  input logic             ready,
  input timerPkg::busRspT rsp,
  input timerPkg::irqT    isr,
  input logic             irq,
  input logic             pwmOut
);
  timeunit 1ns;
  timeprecision 1ps;

  logic readAccept;

  assign readAccept = req.valid & ready & ~req.write;

  readResponse: assert property (@(posedge Clk) disable iff (reset) readAccept |=> rsp.rValid)
    else $error("Read accepted without a response one cycle later");

  noStrayResponse: assert property (@(posedge Clk) disable iff (reset)
                                    rsp.rValid |-> $past(readAccept))
    else $error("Read response without an accepted read");

  irqFollowsIsr: assert property (@(posedge Clk) disable iff (reset) (isr == '0) |-> !irq)
    else $error("Interrupt high with an empty status register");

  // Output held low from the first reset edge on
  pwmQuietInReset: assert property (@(posedge Clk) (reset && $past(reset)) |-> !pwmOut)
    else $error("PWM output moved during reset");

endmodule

bind pwmTimer timerAssert timerAssert_i (
  .Clk(Clk), .reset(reset), .req(req), .ready(ready), .rsp(rsp),
  .isr(regs_i.isr), .irq(irq), .pwmOut(pwmOut)
);

`default_nettype wire

// ==== tests/timerTb.sv ====
`default_nettype none
`include "timer_config.svh"

module timerTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int VecDepth = 256;

  logic Clk;
  logic reset;
  logic ready;
  logic pwmOut;
  logic irq;
  logic [`NUM_EVENTS-1:0] evPin;
  timerPkg::busReqT req;
  timerPkg::busRspT rsp;

  logic [23:0] vectors [0:VecDepth-1];   // op, addr, data per entry
  int cycles = 0;
  int maxCycles = 1000000;

  pwmTimer pwmTimer_i (
    .Clk(Clk), .reset(reset), .req(req), .ready(ready), .rsp(rsp),
    .evPin(evPin), .pwmOut(pwmOut), .irq(irq)
  );

  initial begin
    Clk = 1'b0;
    forever #20 Clk = ~Clk;
  end

  task automatic stopWithError(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Run stopped");
  endtask

  always @(posedge Clk) begin
    cycles = cycles + 1;
    if (cycles > maxCycles)
      stopWithError($sformatf("Timeout after %0d cycles, vectors did not finish", cycles));
  end

  task automatic compareData(input int testName, input logic [`TIMER_WIDTH-1:0] expected,
                             input logic [`TIMER_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL test %0d: expected 0x%04h, actual 0x%04h", testName, expected, actual);
      $display("Checks failed");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic compareBit(input int testName, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL test %0d: expected %b, actual %b", testName, expected, actual);
      $display("Checks failed");
      $fatal(1, "Bit mismatch");
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge Clk);
      #1;
    end
  endtask

  task automatic busWrite(input logic [`ADDR_WIDTH-1:0] addr,
                          input logic [`BUS_DATA_WIDTH-1:0] data);
    req.valid = 1'b1;
    req.write = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    @(posedge Clk);
    while (ready !== 1'b1) @(posedge Clk);
    #1;
    req = '0;
  endtask

  task automatic busRead(input logic [`ADDR_WIDTH-1:0] addr,
                         output logic [`BUS_DATA_WIDTH-1:0] data);
    int tries;
    req.valid = 1'b1;
    req.write = 1'b0;
    req.addr  = addr;
    req.wdata = '0;
    @(posedge Clk);
    while (ready !== 1'b1) @(posedge Clk);
    #1;
    req = '0;
    tries = 0;
    while (rsp.rValid !== 1'b1) begin  // Response is due right after the accepting edge
      if (tries == 4) stopWithError("No read response within 4 cycles");
      @(posedge Clk);
      #1;
      tries++;
    end
    data = rsp.rdata;
  endtask

  initial begin
    int idx;
    int total;
    logic done;
    logic [3:0] op;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [15:0] data;
    logic [`BUS_DATA_WIDTH-1:0] rdata;
    req   = '0;
    evPin = '0;
    reset = 1'b1;
    $readmemh("tests/timer_vectors.txt", vectors);

    // Timeout limit from the vector lengths, doubled for margin
    total = 4;
    idx = 0;
    while (idx < VecDepth && vectors[idx][23:20] != 4'h0) begin
      if (vectors[idx][23:20] == 4'h3) total += int'(vectors[idx][15:0]) + 1;
      else total += 3;
      idx++;
    end
    if (idx == 0) stopWithError("No vectors loaded from tests/timer_vectors.txt");
    maxCycles = 2 * total + 50;

    repeat (4) @(posedge Clk);
    #1;
    reset = 1'b0;

    done = 1'b0;
    idx = 0;
    while (!done && idx < VecDepth) begin
      op   = vectors[idx][23:20];
      addr = vectors[idx][19:16];
      data = vectors[idx][15:0];
      case (op)
        4'h0: done = 1'b1;
        4'h1: busWrite(addr, data);
        4'h2: begin
          busRead(addr, rdata);
          compareData(idx, data, rdata[`TIMER_WIDTH-1:0]);
        end
        4'h3: idleCycles(int'(data));
        4'h4: evPin = data[`NUM_EVENTS-1:0];       // Still 1 ns after the edge
        4'h5: compareBit(idx, data[0], pwmOut);
        4'h6: compareBit(idx, data[0], irq);
        default: stopWithError($sformatf("Vector %0d has an unknown opcode %h", idx, op));
      endcase
      idx++;
    end

    if (done) begin
      $display("All checks passed");
      $finish;
    end else begin
      stopWithError("The vector file has no end entry");
    end
  end

endmodule

`default_nettype wire

// ==== tests/timer_vectors.txt ====
// One hex word per entry: op[23:20] addr[19:16] data[15:0]
// op 1 write, 2 read and expect data, 3 wait data cycles, 4 set pins, 5 expect pwm, 6 expect irq, 0 end
110055 // MODE readback
210055
1200A6 // EVCFG readback
2200A6
130015 // IEN readback
230015
1B0001 // POLARITY active low
2B0001
500001
1B0000
500000
170123 // PERIOD readback
270123
190042 // COMPARE readback
290042
2C0000 // Unused word reads 0
200000 // CTRL reads 0
110000
120000
130000
170014 // Shadow transfer, period 20
19000A
100001
100004
180028 // PERIOD_SH 40 while running
270014
280028
30000A
270014
30000A
270028 // Transferred after wrap
100002
170009 // PWM, period 9 compare 4
190004
100001
100004
300006
100002 // Stop with value 7
260007
500001
1B0001
500000
1B0000
100001
260000
500000
120009 // Event0 filter 2, rising edge
110008 // Start on event0
250000
400001 // Short pulse is filtered out
300003
400000
30000A
250000
400001 // Long level starts the timer
30000A
250001
400000
100002
110000 // Period match interrupt
100001
130010
100004
30000C
600001
240010
100002
140010
600000
240000
130000 // Disabled source stays quiet
100001
100004
300019
600000
240000
100002
110060 // Single shot counting down
100001
130004
100004
30000F
250000
260009
600001
240004
140004
600000
000000

// ==== tb.f ====
+incdir+logic
logic/timerPkg.sv
logic/eventConditioner.sv
logic/timerCore.sv
logic/timerRegs.sv
logic/pwmTimer.sv
tests/timer_assert.sv
tests/timerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PWM timer testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module timerTb -o timerSim &&
./obj_dir/timerSim ||
{
  echo "Simulation did not pass"
  exit 1
}
